//--- verilog/mfu_pkg.sv
// Shared definitions of the vector multiply unit
// Widths, opcode and element-width encodings, operation structs and helpers

`default_nettype none

package mfu_pkg;

  localparam int unsigned ElenBits = 64;
  localparam int unsigned NrVInsn  = 8;

  typedef logic [ElenBits-1:0]   elen_t;
  typedef logic [ElenBits/8-1:0] strb_t;
  typedef logic [2:0]            vid_t;
  typedef logic [11:0]           vlen_t;
  typedef logic [9:0]            vaddr_t;
  typedef logic [4:0]            vreg_t;

  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} vew_e;

  typedef enum logic [1:0] {VMUL, VMULH, VMULHU, VMACC} mul_op_e;

  // One vector instruction as handed over by the lane sequencer
  typedef struct packed {
    mul_op_e op;
    vew_e    vsew;
    vlen_t   vl;
    vreg_t   vd;
    vid_t    id;
    logic    vm;
    logic    use_scalar_op;
    elen_t   scalar_op;
  } mfu_operation_t;

  // One 64-bit word of work for the multiplier
  typedef struct packed {
    mul_op_e op;
    vew_e    vsew;
    logic    use_scalar;
    elen_t   vs1;
    elen_t   vs2;
    elen_t   vd;
    strb_t   mask;
    strb_t   tag;
  } mul_uop_t;

  // Elements in the next word, given the elements still left
  function automatic logic [3:0] word_elems(input vlen_t rem, input vew_e vsew);
    logic [3:0] per_word;
    per_word = 4'd8 >> vsew;
    if (vlen_t'(per_word) > rem) return rem[3:0];
    return per_word;
  endfunction

  // Byte enable covering the first cnt elements of a word
  function automatic strb_t be_for(input logic [3:0] cnt, input vew_e vsew);
    strb_t be;
    be = '0;
    for (int b = 0; b < ElenBits/8; b++) begin
      if ((b >> vsew) < cnt) be[b] = 1'b1;
    end
    return be;
  endfunction

endpackage

`default_nettype wire

//--- verilog/mfu_decode.sv
// Instruction queue and micro-operation issue of the multiply unit
// Holds accepted instructions and pairs them with operands and mask

`timescale 1ns/1ps
`default_nettype none

module mfu_decode #(
  parameter int unsigned InsnQueueDepth = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  mfu_pkg::mfu_operation_t       op_i,
  input  logic                          op_valid_i,
  output logic                          op_ready_o,
  input  mfu_pkg::elen_t          [2:0] operand_i,
  input  logic                    [2:0] operand_valid_i,
  output logic                    [2:0] operand_ready_o,
  input  mfu_pkg::strb_t                mask_i,
  input  logic                          mask_valid_i,
  output logic                          mask_ready_o,
  output mfu_pkg::mul_uop_t             uop_o,
  output logic                          uop_valid_o,
  input  logic                          uop_ready_i,
  output mfu_pkg::mfu_operation_t       proc_insn_o,
  output logic                          proc_valid_o,
  output mfu_pkg::mfu_operation_t       commit_insn_o,
  output logic                          commit_valid_o,
  input  logic                          proc_done_i,
  input  logic                          commit_done_i
);

  import mfu_pkg::*;

  localparam int unsigned PtrW = (InsnQueueDepth > 1) ? $clog2(InsnQueueDepth) : 1;

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [PtrW:0]   cnt_t;

  mfu_operation_t queue_q [InsnQueueDepth];

  ptr_t  accept_pnt_q, accept_pnt_d;
  ptr_t  issue_pnt_q, issue_pnt_d;
  ptr_t  proc_pnt_q, proc_pnt_d;
  ptr_t  commit_pnt_q, commit_pnt_d;
  cnt_t  issue_cnt_q, issue_cnt_d;
  cnt_t  proc_cnt_q, proc_cnt_d;
  cnt_t  commit_cnt_q, commit_cnt_d;
  // Elements of the issuing instruction not yet sent
  vlen_t issue_rem_q, issue_rem_d;

  mfu_operation_t issue_insn;
  logic           issue_valid;
  logic           need_vs1, need_vd, need_mask;
  logic           operands_ok, fire, accept;
  logic [3:0]     issue_elems;

  function automatic ptr_t bump(input ptr_t p);
    return (p == ptr_t'(InsnQueueDepth-1)) ? '0 : p + 1'b1;
  endfunction

  assign issue_insn  = queue_q[issue_pnt_q];
  assign issue_valid = (issue_cnt_q != '0);
  assign need_vs1    = !issue_insn.use_scalar_op;
  assign need_vd     = (issue_insn.op == VMACC);
  assign need_mask   = !issue_insn.vm;
  assign issue_elems = word_elems(issue_rem_q, issue_insn.vsew);

  assign operands_ok = operand_valid_i[1] && (operand_valid_i[0] || !need_vs1) &&
                       (operand_valid_i[2] || !need_vd) && (mask_valid_i || !need_mask);
  assign uop_valid_o = issue_valid && operands_ok;
  assign fire        = uop_valid_o && uop_ready_i;

  assign operand_ready_o = fire ? {need_vd, 1'b1, need_vs1} : 3'b000;
  assign mask_ready_o    = fire && need_mask;

  always_comb begin
    uop_o.op         = issue_insn.op;
    uop_o.vsew       = issue_insn.vsew;
    uop_o.use_scalar = issue_insn.use_scalar_op;
    uop_o.vs1        = issue_insn.use_scalar_op ? issue_insn.scalar_op : operand_i[0];
    uop_o.vs2        = operand_i[1];
    uop_o.vd         = operand_i[2];
    // Unmasked instructions write every byte the tail allows
    uop_o.mask       = issue_insn.vm ? '1 : mask_i;
    uop_o.tag        = be_for(issue_elems, issue_insn.vsew);
  end

  assign op_ready_o     = (commit_cnt_q != cnt_t'(InsnQueueDepth));
  assign accept         = op_valid_i && op_ready_o;
  assign proc_insn_o    = queue_q[proc_pnt_q];
  assign proc_valid_o   = (proc_cnt_q != '0);
  assign commit_insn_o  = queue_q[commit_pnt_q];
  assign commit_valid_o = (commit_cnt_q != '0);

  always_comb begin
    accept_pnt_d = accept_pnt_q;
    issue_pnt_d  = issue_pnt_q;
    proc_pnt_d   = proc_pnt_q;
    commit_pnt_d = commit_pnt_q;
    issue_cnt_d  = issue_cnt_q;
    proc_cnt_d   = proc_cnt_q;
    commit_cnt_d = commit_cnt_q;
    issue_rem_d  = issue_rem_q;

    if (fire) begin
      issue_rem_d = issue_rem_q - vlen_t'(issue_elems);
      if (issue_rem_d == '0) begin
        issue_pnt_d = bump(issue_pnt_q);
        issue_cnt_d = issue_cnt_q - 1'b1;
        // Move on to the next queued instruction, if any
        if (issue_cnt_d != '0) issue_rem_d = queue_q[issue_pnt_d].vl;
      end
    end

    if (proc_done_i) begin
      proc_pnt_d = bump(proc_pnt_q);
      proc_cnt_d = proc_cnt_q - 1'b1;
    end

    if (commit_done_i) begin
      commit_pnt_d = bump(commit_pnt_q);
      commit_cnt_d = commit_cnt_q - 1'b1;
    end

    if (accept) begin
      if (issue_cnt_d == '0) issue_rem_d = op_i.vl;
      accept_pnt_d = bump(accept_pnt_q);
      issue_cnt_d  = issue_cnt_d + 1'b1;
      proc_cnt_d   = proc_cnt_d + 1'b1;
      commit_cnt_d = commit_cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) queue_q[accept_pnt_q] <= op_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      proc_pnt_q   <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      proc_cnt_q   <= '0;
      commit_cnt_q <= '0;
      issue_rem_q  <= '0;
    end else begin
      accept_pnt_q <= accept_pnt_d;
      issue_pnt_q  <= issue_pnt_d;
      proc_pnt_q   <= proc_pnt_d;
      commit_pnt_q <= commit_pnt_d;
      issue_cnt_q  <= issue_cnt_d;
      proc_cnt_q   <= proc_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      issue_rem_q  <= issue_rem_d;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mfu_simd_mul.sv
// SIMD integer multiplier for 8, 16, 32 and 64-bit elements
// Fixed-latency pipeline that stalls as a whole on output back-pressure

`timescale 1ns/1ps
`default_nettype none

module mfu_simd_mul #(
  parameter int unsigned MulLatency = 2
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  mfu_pkg::mul_uop_t   uop_i,
  input  logic                uop_valid_i,
  output logic                uop_ready_o,
  output mfu_pkg::elen_t      res_o,
  output mfu_pkg::strb_t      res_be_o,
  output logic                res_valid_o,
  input  logic                res_ready_i
);

  import mfu_pkg::*;

  typedef struct packed {
    elen_t res;
    strb_t mask;
    strb_t tag;
  } stage_t;

  elen_t                     scalar_rep;
  elen_t                     op_a;
  logic                      sgn;
  logic [3:0][ElenBits-1:0]  ew_res;
  stage_t                    stage_d;
  stage_t                    stage_q [MulLatency];
  logic [MulLatency-1:0]     valid_q;
  logic                      stall;

  // Scalar broadcast to every element of the word
  always_comb begin
    case (uop_i.vsew)
      EW8:     scalar_rep = {8{uop_i.vs1[7:0]}};
      EW16:    scalar_rep = {4{uop_i.vs1[15:0]}};
      EW32:    scalar_rep = {2{uop_i.vs1[31:0]}};
      default: scalar_rep = uop_i.vs1;
    endcase
  end

  assign op_a = uop_i.use_scalar ? scalar_rep : uop_i.vs1;
  // Only the signed high product needs sign-extended operands
  assign sgn  = (uop_i.op == VMULH);

  for (genvar e = 0; e < 4; e++) begin : g_ew
    localparam int unsigned W = 8 << e;
    for (genvar l = 0; l < ElenBits / W; l++) begin : g_lane
      logic signed [W:0]     a_x;
      logic signed [W:0]     b_x;
      logic signed [2*W+1:0] prod;
      logic [W-1:0]          lane_res;

      assign a_x  = {sgn & op_a[l*W+W-1], op_a[l*W +: W]};
      assign b_x  = {sgn & uop_i.vs2[l*W+W-1], uop_i.vs2[l*W +: W]};
      assign prod = a_x * b_x;

      assign lane_res = (uop_i.op == VMULH || uop_i.op == VMULHU) ? prod[2*W-1:W] :
                        (uop_i.op == VMACC) ? prod[W-1:0] + uop_i.vd[l*W +: W] :
                        prod[W-1:0];
      assign ew_res[e][l*W +: W] = lane_res;
    end
  end

  assign stage_d.res  = ew_res[uop_i.vsew];
  assign stage_d.mask = uop_i.mask;
  assign stage_d.tag  = uop_i.tag;

  assign stall       = valid_q[MulLatency-1] && !res_ready_i;
  assign uop_ready_o = !stall;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (!stall) begin
      valid_q[0] <= uop_valid_i;
      for (int s = 1; s < MulLatency; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall) begin
      stage_q[0] <= stage_d;
      for (int s = 1; s < MulLatency; s++) begin
        stage_q[s] <= stage_q[s-1];
      end
    end
  end

  assign res_valid_o = valid_q[MulLatency-1];
  assign res_o       = stage_q[MulLatency-1].res;
  assign res_be_o    = stage_q[MulLatency-1].mask & stage_q[MulLatency-1].tag;

endmodule

`default_nettype wire

//--- verilog/mfu_result.sv
// Result stage of the multiply unit
// Two-entry result queue toward the register file and per-instruction done

`timescale 1ns/1ps
`default_nettype none

module mfu_result #(
  parameter int unsigned RegWords = 16
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  mfu_pkg::elen_t                      res_i,
  input  mfu_pkg::strb_t                      res_be_i,
  input  logic                                res_valid_i,
  output logic                                res_ready_o,
  input  mfu_pkg::mfu_operation_t             proc_insn_i,
  input  logic                                proc_valid_i,
  input  mfu_pkg::mfu_operation_t             commit_insn_i,
  input  logic                                commit_valid_i,
  output logic                                proc_done_o,
  output logic                                commit_done_o,
  output logic                                result_req_o,
  output mfu_pkg::vid_t                       result_id_o,
  output mfu_pkg::vaddr_t                     result_addr_o,
  output mfu_pkg::elen_t                      result_wdata_o,
  output mfu_pkg::strb_t                      result_be_o,
  input  logic                                result_gnt_i,
  output logic          [mfu_pkg::NrVInsn-1:0] vinsn_done_o
);

  import mfu_pkg::*;

  localparam int unsigned ResultQueueDepth = 2;
  localparam int unsigned QPtrW = $clog2(ResultQueueDepth);

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } payload_t;

  payload_t                      queue_q [ResultQueueDepth];
  logic [ResultQueueDepth-1:0]   valid_q;
  logic [QPtrW-1:0]              wr_pnt_q, rd_pnt_q;
  logic [QPtrW:0]                cnt_q;

  // Elements already handled for the current instruction of each phase
  vlen_t      proc_elems_q, commit_elems_q;
  logic [3:0] proc_word, commit_word;
  logic       proc_last, commit_last;
  logic       push, pop;
  vaddr_t     word_idx;
  payload_t   entry;

  assign res_ready_o = (cnt_q != (QPtrW+1)'(ResultQueueDepth));
  assign push        = res_valid_i && res_ready_o && proc_valid_i;
  assign pop         = result_req_o && result_gnt_i;

  assign proc_word = word_elems(proc_insn_i.vl - proc_elems_q, proc_insn_i.vsew);
  assign proc_last = (proc_elems_q + vlen_t'(proc_word)) == proc_insn_i.vl;
  assign word_idx  = vaddr_t'(proc_elems_q >> (3 - int'(proc_insn_i.vsew)));

  assign entry.id    = proc_insn_i.id;
  assign entry.addr  = vaddr_t'(proc_insn_i.vd) * vaddr_t'(RegWords) + word_idx;
  assign entry.wdata = res_i;
  assign entry.be    = res_be_i & be_for(proc_word, proc_insn_i.vsew);

  assign proc_done_o = push && proc_last;

  assign commit_word   = word_elems(commit_insn_i.vl - commit_elems_q, commit_insn_i.vsew);
  assign commit_last   = (commit_elems_q + vlen_t'(commit_word)) == commit_insn_i.vl;
  assign commit_done_o = pop && commit_valid_i && commit_last;

  always_comb begin
    vinsn_done_o                   = '0;
    vinsn_done_o[commit_insn_i.id] = commit_done_o;
  end

  assign result_req_o   = valid_q[rd_pnt_q];
  assign result_id_o    = queue_q[rd_pnt_q].id;
  assign result_addr_o  = queue_q[rd_pnt_q].addr;
  assign result_wdata_o = queue_q[rd_pnt_q].wdata;
  assign result_be_o    = queue_q[rd_pnt_q].be;

  always_ff @(posedge clk_i) begin
    if (push) queue_q[wr_pnt_q] <= entry;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q        <= '0;
      wr_pnt_q       <= '0;
      rd_pnt_q       <= '0;
      cnt_q          <= '0;
      proc_elems_q   <= '0;
      commit_elems_q <= '0;
    end else begin
      if (pop) begin
        valid_q[rd_pnt_q] <= 1'b0;
        rd_pnt_q          <= rd_pnt_q + 1'b1;
      end
      if (push) begin
        valid_q[wr_pnt_q] <= 1'b1;
        wr_pnt_q          <= wr_pnt_q + 1'b1;
        proc_elems_q      <= proc_last ? '0 : proc_elems_q + vlen_t'(proc_word);
      end
      if (pop && commit_valid_i) begin
        commit_elems_q <= commit_last ? '0 : commit_elems_q + vlen_t'(commit_word);
      end
      cnt_q <= cnt_q + push - pop;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mfu_top.sv
// Vector integer multiply unit of one lane
// Decode, SIMD multiply and result stages in a row

`timescale 1ns/1ps
`default_nettype none

module mfu_top #(
  parameter int unsigned InsnQueueDepth = 4,
  parameter int unsigned MulLatency     = 2,
  parameter int unsigned RegWords       = 16
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  mfu_pkg::mfu_operation_t              op_i,
  input  logic                                 op_valid_i,
  output logic                                 op_ready_o,
  input  mfu_pkg::elen_t                 [2:0] operand_i,
  input  logic                           [2:0] operand_valid_i,
  output logic                           [2:0] operand_ready_o,
  input  mfu_pkg::strb_t                       mask_i,
  input  logic                                 mask_valid_i,
  output logic                                 mask_ready_o,
  output logic                                 result_req_o,
  output mfu_pkg::vid_t                        result_id_o,
  output mfu_pkg::vaddr_t                      result_addr_o,
  output mfu_pkg::elen_t                       result_wdata_o,
  output mfu_pkg::strb_t                       result_be_o,
  input  logic                                 result_gnt_i,
  output logic          [mfu_pkg::NrVInsn-1:0] vinsn_done_o
);

  import mfu_pkg::*;

  mul_uop_t       uop;
  logic           uop_valid, uop_ready;
  elen_t          res;
  strb_t          res_be;
  logic           res_valid, res_ready;
  mfu_operation_t proc_insn, commit_insn;
  logic           proc_valid, commit_valid;
  logic           proc_done, commit_done;

  mfu_decode #(
    .InsnQueueDepth(InsnQueueDepth)
  ) u_mfu_decode (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .op_i           (op_i),
    .op_valid_i     (op_valid_i),
    .op_ready_o     (op_ready_o),
    .operand_i      (operand_i),
    .operand_valid_i(operand_valid_i),
    .operand_ready_o(operand_ready_o),
    .mask_i         (mask_i),
    .mask_valid_i   (mask_valid_i),
    .mask_ready_o   (mask_ready_o),
    .uop_o          (uop),
    .uop_valid_o    (uop_valid),
    .uop_ready_i    (uop_ready),
    .proc_insn_o    (proc_insn),
    .proc_valid_o   (proc_valid),
    .commit_insn_o  (commit_insn),
    .commit_valid_o (commit_valid),
    .proc_done_i    (proc_done),
    .commit_done_i  (commit_done)
  );

  mfu_simd_mul #(
    .MulLatency(MulLatency)
  ) u_mfu_simd_mul (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .uop_i      (uop),
    .uop_valid_i(uop_valid),
    .uop_ready_o(uop_ready),
    .res_o      (res),
    .res_be_o   (res_be),
    .res_valid_o(res_valid),
    .res_ready_i(res_ready)
  );

  mfu_result #(
    .RegWords(RegWords)
  ) u_mfu_result (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .res_i         (res),
    .res_be_i      (res_be),
    .res_valid_i   (res_valid),
    .res_ready_o   (res_ready),
    .proc_insn_i   (proc_insn),
    .proc_valid_i  (proc_valid),
    .commit_insn_i (commit_insn),
    .commit_valid_i(commit_valid),
    .proc_done_o   (proc_done),
    .commit_done_o (commit_done),
    .result_req_o  (result_req_o),
    .result_id_o   (result_id_o),
    .result_addr_o (result_addr_o),
    .result_wdata_o(result_wdata_o),
    .result_be_o   (result_be_o),
    .result_gnt_i  (result_gnt_i),
    .vinsn_done_o  (vinsn_done_o)
  );

endmodule

`default_nettype wire

//--- verif/mfu_checker.sv
// Result checker of the multiply unit testbench
// Compares each granted register-file write and every done pulse with expected values

`timescale 1ns/1ps
`default_nettype none

module mfu_checker (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        exp_valid_i,
  input  mfu_pkg::vid_t               exp_id_i,
  input  mfu_pkg::vaddr_t             exp_addr_i,
  input  mfu_pkg::elen_t              exp_wdata_i,
  input  mfu_pkg::strb_t              exp_be_i,
  input  logic                        exp_last_i,
  input  logic                        result_req_i,
  input  mfu_pkg::vid_t               result_id_i,
  input  mfu_pkg::vaddr_t             result_addr_i,
  input  mfu_pkg::elen_t              result_wdata_i,
  input  mfu_pkg::strb_t              result_be_i,
  input  logic                        result_gnt_i,
  input  logic [mfu_pkg::NrVInsn-1:0] vinsn_done_i
);

  import mfu_pkg::*;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
    logic   last;
  } exp_t;

  exp_t               exp_q [$];
  exp_t               incoming;
  exp_t               cur;
  logic [NrVInsn-1:0] done_exp;
  int unsigned        err_cnt = 0;
  int unsigned        word_cnt = 0;
  // Expected writes not yet granted
  int unsigned        pending = 0;

  assign incoming = {exp_id_i, exp_addr_i, exp_wdata_i, exp_be_i, exp_last_i};

  task automatic compare_field(input string name, input logic [63:0] got,
                               input logic [63:0] want);
    if (got !== want) begin
      $display("ERR %s got %h expected %h at address %h", name, got, want, cur.addr);
      err_cnt++;
    end
  endtask

  always @(posedge clk_i) begin
    if (exp_valid_i) exp_q.push_back(incoming);
    done_exp = '0;
    if (rst_ni && result_req_i && result_gnt_i) begin
      if (exp_q.size() == 0) begin
        $display("Write to address %h was granted while no result was expected",
                 result_addr_i);
        err_cnt++;
      end else begin
        cur = exp_q.pop_front();
        word_cnt++;
        compare_field("result_id_o", 64'(result_id_i), 64'(cur.id));
        compare_field("result_addr_o", 64'(result_addr_i), 64'(cur.addr));
        compare_field("result_wdata_o", result_wdata_i, cur.wdata);
        compare_field("result_be_o", 64'(result_be_i), 64'(cur.be));
        // Done belongs to the grant of the last word
        if (cur.last) done_exp[cur.id] = 1'b1;
      end
    end
    if (rst_ni && (vinsn_done_i !== done_exp)) begin
      $display("ERR vinsn_done_o got %h expected %h", vinsn_done_i, done_exp);
      err_cnt++;
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

//--- verif/tb_mfu.sv
// Testbench of the vector multiply unit
// Drives instructions, operands and grants, and feeds expected writes to the checker

`timescale 1ns/1ps
`default_nettype none

module tb_mfu;

  import mfu_pkg::*;

  localparam int unsigned InsnQueueDepth = 4;
  localparam int unsigned MulLatency     = 2;
  localparam int unsigned RegWords       = 16;
  localparam int unsigned WaitLimit      = 1000;

  typedef enum logic [1:0] {GntAlways, GntHold, GntRandom} gnt_mode_e;

  // Operand words of one micro-operation
  typedef struct packed {
    elen_t      vs1;
    elen_t      vs2;
    elen_t      vd;
    strb_t      mask;
    // Readies expected in the cycle the word is consumed
    logic [2:0] ready;
    logic       mask_ready;
  } word_t;

  logic               clk_i = 1'b0;
  logic               rst_ni = 1'b0;
  mfu_operation_t     op_i = '0;
  logic               op_valid_i = 1'b0;
  logic               op_ready_o;
  elen_t        [2:0] operand_i = '0;
  logic         [2:0] operand_valid_i = '0;
  logic         [2:0] operand_ready_o;
  strb_t              mask_i = '0;
  logic               mask_valid_i = 1'b0;
  logic               mask_ready_o;
  logic               result_req_o;
  vid_t               result_id_o;
  vaddr_t             result_addr_o;
  elen_t              result_wdata_o;
  strb_t              result_be_o;
  logic               result_gnt_i = 1'b0;
  logic [NrVInsn-1:0] vinsn_done_o;

  logic   exp_valid = 1'b0;
  vid_t   exp_id = '0;
  vaddr_t exp_addr = '0;
  elen_t  exp_wdata = '0;
  strb_t  exp_be = '0;
  logic   exp_last = 1'b0;

  gnt_mode_e      gnt_mode = GntAlways;
  mfu_operation_t op_list [$];
  word_t          word_list [$];
  vid_t           next_id = '0;
  int unsigned    tb_err_cnt = 0;
  int unsigned    err_base = 0;
  int unsigned    word_base = 0;
  int unsigned    test_cnt = 0;
  int unsigned    failed_cnt = 0;

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    case (gnt_mode)
      GntAlways: result_gnt_i <= 1'b1;
      GntHold:   result_gnt_i <= 1'b0;
      default:   result_gnt_i <= ($urandom % 3) != 0;
    endcase
  end

  mfu_top #(
    .InsnQueueDepth(InsnQueueDepth),
    .MulLatency    (MulLatency),
    .RegWords      (RegWords)
  ) u_mfu_top (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .op_i           (op_i),
    .op_valid_i     (op_valid_i),
    .op_ready_o     (op_ready_o),
    .operand_i      (operand_i),
    .operand_valid_i(operand_valid_i),
    .operand_ready_o(operand_ready_o),
    .mask_i         (mask_i),
    .mask_valid_i   (mask_valid_i),
    .mask_ready_o   (mask_ready_o),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i),
    .vinsn_done_o   (vinsn_done_o)
  );

  mfu_checker u_mfu_checker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .exp_valid_i   (exp_valid),
    .exp_id_i      (exp_id),
    .exp_addr_i    (exp_addr),
    .exp_wdata_i   (exp_wdata),
    .exp_be_i      (exp_be),
    .exp_last_i    (exp_last),
    .result_req_i  (result_req_o),
    .result_id_i   (result_id_o),
    .result_addr_i (result_addr_o),
    .result_wdata_i(result_wdata_o),
    .result_be_i   (result_be_o),
    .result_gnt_i  (result_gnt_i),
    .vinsn_done_i  (vinsn_done_o)
  );

  // Scalar copied into every element of the word
  function automatic elen_t replicate(input elen_t s, input vew_e vsew);
    int    w;
    elen_t m;
    elen_t r;
    w = 8 << int'(vsew);
    m = elen_t'((128'd1 << w) - 128'd1);
    r = '0;
    for (int l = 0; l < 64 / w; l++) begin
      r = r | ((s & m) << (l * w));
    end
    return r;
  endfunction

  function automatic strb_t tail_be(input int elems, input vew_e vsew);
    strb_t be;
    be = '0;
    for (int b = 0; b < 8; b++) begin
      if (b / (1 << int'(vsew)) < elems) be[b] = 1'b1;
    end
    return be;
  endfunction

  // Expected result word, element by element at full precision
  function automatic elen_t ref_result(input mul_op_e op, input vew_e vsew, input elen_t a,
                                       input elen_t b, input elen_t c);
    int           w;
    logic [127:0] m;
    logic [127:0] ea;
    logic [127:0] eb;
    logic [127:0] ec;
    logic [127:0] p;
    logic [127:0] r;
    elen_t        res;
    w = 8 << int'(vsew);
    m = (128'd1 << w) - 128'd1;
    res = '0;
    for (int l = 0; l < 64 / w; l++) begin
      ea = (128'(a) >> (l * w)) & m;
      eb = (128'(b) >> (l * w)) & m;
      ec = (128'(c) >> (l * w)) & m;
      if (op == VMULH) begin
        if (ea[w-1]) ea = ea | ~m;
        if (eb[w-1]) eb = eb | ~m;
      end
      p = ea * eb;
      case (op)
        VMULH, VMULHU: r = p >> w;
        VMACC:         r = p + ec;
        default:       r = p;
      endcase
      res = res | elen_t'((r & m) << (l * w));
    end
    return res;
  endfunction

  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic check_out(input string name, input logic [63:0] got, input logic [63:0] want);
    if (got !== want) begin
      $display("ERR %s got %h expected %h", name, got, want);
      tb_err_cnt++;
    end
  endtask

  // Queues one instruction with its operand words and loads its expected writes
  task automatic add_insn(input mul_op_e op, input vew_e vsew, input int vl, input int vd,
                          input logic vm, input logic use_scalar);
    mfu_operation_t insn;
    word_t          w;
    elen_t          a;
    strb_t          be;
    int             per;
    int             left;
    int             n;
    int             idx;
    insn.op            = op;
    insn.vsew          = vsew;
    insn.vl            = vlen_t'(vl);
    insn.vd            = vreg_t'(vd);
    insn.id            = next_id;
    insn.vm            = vm;
    insn.use_scalar_op = use_scalar;
    insn.scalar_op     = {$urandom, $urandom};
    next_id = next_id + vid_t'(1);
    op_list.push_back(insn);
    per  = 8 >> int'(vsew);
    left = vl;
    idx  = 0;
    while (left > 0) begin
      n      = (left < per) ? left : per;
      w.vs1  = {$urandom, $urandom};
      w.vs2  = {$urandom, $urandom};
      w.vd   = {$urandom, $urandom};
      w.mask = strb_t'($urandom);
      // vs2 is always taken, vs1 only without scalar, vd only for VMACC
      w.ready      = {op == VMACC, 1'b1, !use_scalar};
      w.mask_ready = !vm;
      word_list.push_back(w);
      a  = use_scalar ? replicate(insn.scalar_op, vsew) : w.vs1;
      be = tail_be(n, vsew);
      if (!vm) be = be & w.mask;
      exp_valid <= 1'b1;
      exp_id    <= insn.id;
      exp_addr  <= vaddr_t'(vd * RegWords + idx);
      exp_wdata <= ref_result(op, vsew, a, w.vs2, w.vd);
      exp_be    <= be;
      exp_last  <= (left == n);
      @(posedge clk_i);
      left = left - n;
      idx++;
    end
    exp_valid <= 1'b0;
  endtask

  task automatic send_ops();
    int unsigned guard;
    foreach (op_list[i]) begin
      op_i       <= op_list[i];
      op_valid_i <= 1'b1;
      guard = 0;
      @(posedge clk_i);
      while (!op_ready_o && guard < WaitLimit) begin
        guard++;
        @(posedge clk_i);
      end
      if (!op_ready_o) abort_run("op_ready_o stayed low, instruction never accepted");
    end
    op_valid_i <= 1'b0;
  endtask

  // All operands and the mask are offered, and vs2 is taken by every issue
  task automatic send_operands();
    int unsigned guard;
    foreach (word_list[i]) begin
      operand_i       <= {word_list[i].vd, word_list[i].vs2, word_list[i].vs1};
      operand_valid_i <= 3'b111;
      mask_i          <= word_list[i].mask;
      mask_valid_i    <= 1'b1;
      guard = 0;
      @(posedge clk_i);
      while (!operand_ready_o[1] && guard < WaitLimit) begin
        guard++;
        @(posedge clk_i);
      end
      if (!operand_ready_o[1]) begin
        abort_run("operand word never consumed");
      end else begin
        check_out("operand_ready_o", 64'(operand_ready_o), 64'(word_list[i].ready));
        check_out("mask_ready_o", 64'(mask_ready_o), 64'(word_list[i].mask_ready));
      end
    end
    operand_valid_i <= 3'b000;
    mask_valid_i    <= 1'b0;
  endtask

  task automatic watch_op_ready();
    int unsigned guard;
    guard = 0;
    while (op_ready_o && guard < 100) begin
      guard++;
      @(posedge clk_i);
    end
    if (op_ready_o) begin
      $display("op_ready_o never dropped while grants were held back");
      tb_err_cnt++;
    end
    // Leave the unit stalled for a while
    repeat (10) @(posedge clk_i);
    gnt_mode <= GntRandom;
  endtask

  task automatic run_test(input string name, input logic hold_gnt);
    int unsigned guard;
    int unsigned errs;
    if (hold_gnt) gnt_mode <= GntHold;
    else gnt_mode <= GntAlways;
    fork
      send_ops();
      send_operands();
      begin
        if (hold_gnt) watch_op_ready();
      end
    join
    guard = 0;
    @(negedge clk_i);
    while (u_mfu_checker.pending != 0 && guard < WaitLimit) begin
      guard++;
      @(negedge clk_i);
    end
    if (u_mfu_checker.pending != 0) abort_run("expected writes never reached the register file");
    // A late stray done pulse still gets seen here
    repeat (4) @(negedge clk_i);
    errs = u_mfu_checker.err_cnt + tb_err_cnt - err_base;
    test_cnt++;
    if (errs != 0) failed_cnt++;
    $display("Test %s: %0d words, %0d errors", name, u_mfu_checker.word_cnt - word_base, errs);
    err_base  = u_mfu_checker.err_cnt + tb_err_cnt;
    word_base = u_mfu_checker.word_cnt;
    op_list.delete();
    word_list.delete();
    @(posedge clk_i);
    gnt_mode <= GntAlways;
  endtask

  initial begin
    void'($urandom(32'h9309_5fab));
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_out("op_ready_o", 64'(op_ready_o), 64'd1);
    check_out("result_req_o", 64'(result_req_o), 64'd0);
    check_out("operand_ready_o", 64'(operand_ready_o), 64'd0);
    check_out("mask_ready_o", 64'(mask_ready_o), 64'd0);
    check_out("vinsn_done_o", 64'(vinsn_done_o), 64'd0);
    test_cnt++;
    if (tb_err_cnt != 0) failed_cnt++;
    $display("Test reset: %0d errors", tb_err_cnt);
    err_base = tb_err_cnt;
    @(posedge clk_i);

    // Partial last word at every element width
    add_insn(VMUL, EW8, 13, 1, 1'b1, 1'b0);
    add_insn(VMUL, EW16, 7, 2, 1'b1, 1'b0);
    add_insn(VMUL, EW32, 5, 3, 1'b1, 1'b0);
    add_insn(VMUL, EW64, 3, 4, 1'b1, 1'b0);
    run_test("vmul_tail", 1'b0);

    add_insn(VMULH, EW8, 17, 5, 1'b1, 1'b0);
    add_insn(VMULHU, EW32, 6, 6, 1'b1, 1'b0);
    add_insn(VMULH, EW64, 3, 7, 1'b1, 1'b0);
    add_insn(VMULHU, EW16, 9, 8, 1'b1, 1'b0);
    run_test("high_products", 1'b0);

    add_insn(VMULH, EW16, 10, 9, 1'b1, 1'b1);
    add_insn(VMACC, EW32, 7, 10, 1'b1, 1'b0);
    add_insn(VMACC, EW8, 11, 11, 1'b1, 1'b1);
    run_test("scalar_macc", 1'b0);

    add_insn(VMUL, EW8, 16, 12, 1'b0, 1'b0);
    add_insn(VMACC, EW16, 6, 13, 1'b0, 1'b0);
    add_insn(VMULHU, EW32, 3, 14, 1'b0, 1'b1);
    run_test("mask", 1'b0);

    // Five instructions against withheld and then random grants
    add_insn(VMUL, EW16, 9, 15, 1'b1, 1'b0);
    add_insn(VMULH, EW8, 12, 16, 1'b0, 1'b0);
    add_insn(VMACC, EW32, 4, 17, 1'b1, 1'b0);
    add_insn(VMULHU, EW64, 2, 18, 1'b1, 1'b1);
    add_insn(VMUL, EW8, 20, 19, 1'b0, 1'b0);
    run_test("backpressure", 1'b1);

    $display("%0d tests, %0d failed, %0d words checked, %0d errors", test_cnt, failed_cnt,
             u_mfu_checker.word_cnt, u_mfu_checker.err_cnt + tb_err_cnt);
    if (failed_cnt == 0 && u_mfu_checker.err_cnt + tb_err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
verilog/mfu_pkg.sv
verilog/mfu_decode.sv
verilog/mfu_simd_mul.sv
verilog/mfu_result.sv
verilog/mfu_top.sv
verif/mfu_checker.sv
verif/tb_mfu.sv

//--- run.sh
#!/bin/sh
# Builds the multiply unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_mfu -Mdir obj_dir -o tb_mfu -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_mfu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The log decides the result
if grep -q "Simulation finished: PASS" "$LOG"; then
  exit 0
fi
exit 1
